/* act_fifo.sv */
`timescale 1ns/10ps

module act_fifo #(
    parameter int DATA_WIDTH = 32,
    parameter int DEPTH      = 16
) (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_wr_en,
    input  logic [DATA_WIDTH-1:0] i_wr_data,
    input  logic                  i_rd_en,
    output logic [DATA_WIDTH-1:0] o_rd_data,
    output logic                  o_empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0]      wr_ptr_q;
    logic [PTR_W-1:0]      rd_ptr_q;
    logic [CNT_W-1:0]      count_q;
    logic                  full;
    logic                  do_wr;
    logic                  do_rd;

    // Wraps for any depth, not only powers of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full      = (count_q == CNT_W'(DEPTH));
    assign o_empty   = (count_q == '0);
    assign do_wr     = i_wr_en && !full;    // Dropped when full
    assign do_rd     = i_rd_en && !o_empty;
    assign o_rd_data = mem[rd_ptr_q];       // Show-ahead head word

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr_q] <= i_wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_rd) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({do_wr, do_rd})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

/* model.sv */
`timescale 1ns/10ps
`include "model_settings.svh"

module model
    import model_pkg::*;
(
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  act_t [`L1_IN_CH-1:0]    i_data,
    input  logic                    i_valid,
    input  logic [`WR_DATA_W-1:0]   i_weight_wr_data,
    input  logic [`WR_ADDR_W-1:0]   i_weight_wr_addr,
    input  logic                    i_weight_wr_en,
    output act_t [`L2_OUT_CH-1:0]   o_data,
    output logic                    o_valid,
    output logic                    o_fifo_rd_en
);

    // conv_1
    act_t [`L1_OUT_CH-1:0] conv_1_data;
    logic                  conv_1_valid;

    pw_conv #(
        .IN_CH            (`L1_IN_CH),
        .OUT_CH           (`L1_OUT_CH),
        .KERNEL_BASE      (`L1_KERNEL_BASE),
        .BIAS_BASE        (`L1_BIAS_BASE),
        .SCALE_BASE       (`L1_SCALE_BASE)
    ) u_conv_1 (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_data           (i_data),
        .i_valid          (i_valid),
        .i_weight_wr_en   (i_weight_wr_en),
        .i_weight_wr_addr (i_weight_wr_addr),
        .i_weight_wr_data (i_weight_wr_data),
        .o_fifo_rd_en     (o_fifo_rd_en),
        .o_data           (conv_1_data),
        .o_valid          (conv_1_valid)
    );

    act_t [`L1_OUT_CH-1:0] fifo_conv_1_rd_data;
    logic                  fifo_conv_1_empty;
    logic                  fifo_conv_1_rd_en;

    act_fifo #(
        .DATA_WIDTH       (`L1_OUT_CH * `ACT_W),
        .DEPTH            (`FIFO_DEPTH)
    ) u_fifo_conv_1 (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_wr_en          (conv_1_valid),
        .i_wr_data        (conv_1_data),
        .i_rd_en          (fifo_conv_1_rd_en),
        .o_rd_data        (fifo_conv_1_rd_data),
        .o_empty          (fifo_conv_1_empty)
    );

    // conv_2, fed from the FIFO head
    pw_conv #(
        .IN_CH            (`L1_OUT_CH),
        .OUT_CH           (`L2_OUT_CH),
        .KERNEL_BASE      (`L2_KERNEL_BASE),
        .BIAS_BASE        (`L2_BIAS_BASE),
        .SCALE_BASE       (`L2_SCALE_BASE)
    ) u_conv_2 (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_data           (fifo_conv_1_rd_data),
        .i_valid          (~fifo_conv_1_empty),
        .i_weight_wr_en   (i_weight_wr_en),
        .i_weight_wr_addr (i_weight_wr_addr),
        .i_weight_wr_data (i_weight_wr_data),
        .o_fifo_rd_en     (fifo_conv_1_rd_en),
        .o_data           (o_data),
        .o_valid          (o_valid)     // No back-pressure from the sink
    );

endmodule

/* model_pkg.sv */
`include "model_settings.svh"

package model_pkg;

    typedef logic        [`ACT_W-1:0]   act_t;      // Unsigned activation
    typedef logic signed [`WGT_W-1:0]   weight_t;
    typedef logic signed [`BIAS_W-1:0]  bias_t;
    typedef logic signed [`ACC_W-1:0]   acc_t;
    typedef logic        [`SCALE_W-1:0] scale_t;

    // Per-pixel layer sequence
    typedef enum logic [1:0] {
        LOAD,
        MAC,
        EMIT
    } conv_state_e;

endpackage

/* model_settings.svh */
`ifndef MODEL_SETTINGS_SVH
`define MODEL_SETTINGS_SVH

// Datapath widths
`define ACT_W           8
`define WGT_W           8
`define BIAS_W          16
`define ACC_W           24
`define SCALE_W         5   // Right shift amount

// Shared weight write bus
`define WR_DATA_W       32
`define WR_ADDR_W       32

// Layer sizes, layer 2 input is layer 1 output
`define L1_IN_CH        3
`define L1_OUT_CH       4
`define L2_OUT_CH       2

`define FIFO_DEPTH      16

// Weight address map, one value per address
`define L1_KERNEL_BASE  0   // 12 weights, out channel major
`define L1_BIAS_BASE    12  // 4 biases
`define L1_SCALE_BASE   16
`define L2_KERNEL_BASE  17  // 8 weights
`define L2_BIAS_BASE    25  // 2 biases
`define L2_SCALE_BASE   27

`endif

/* pw_conv.sv */
`timescale 1ns/10ps
`include "model_settings.svh"

module pw_conv
    import model_pkg::*;
#(
    parameter int IN_CH       = `L1_IN_CH,
    parameter int OUT_CH      = `L1_OUT_CH,
    parameter int KERNEL_BASE = `L1_KERNEL_BASE,
    parameter int BIAS_BASE   = `L1_BIAS_BASE,
    parameter int SCALE_BASE  = `L1_SCALE_BASE
) (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  act_t [IN_CH-1:0]      i_data,
    input  logic                  i_valid,
    input  logic                  i_weight_wr_en,
    input  logic [`WR_ADDR_W-1:0] i_weight_wr_addr,
    input  logic [`WR_DATA_W-1:0] i_weight_wr_data,
    output logic                  o_fifo_rd_en,
    output act_t [OUT_CH-1:0]     o_data,
    output logic                  o_valid
);

    localparam int   CH_W    = (OUT_CH > 1) ? $clog2(OUT_CH) : 1;
    localparam acc_t ACT_MAX = acc_t'({`ACT_W{1'b1}});

    weight_t kernel [OUT_CH][IN_CH];
    bias_t   bias [OUT_CH];
    scale_t  scale;

    conv_state_e       state_q;
    logic [CH_W-1:0]   ch_q;        // Output channel being computed
    act_t [IN_CH-1:0]  pixel_q;
    act_t [OUT_CH-1:0] out_q;

    acc_t mac_sum;
    acc_t relu_sum;
    acc_t shifted;
    act_t ch_result;

    weight_bank #(
        .IN_CH            (IN_CH),
        .OUT_CH           (OUT_CH),
        .KERNEL_BASE      (KERNEL_BASE),
        .BIAS_BASE        (BIAS_BASE),
        .SCALE_BASE       (SCALE_BASE)
    ) u_weight_bank (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_weight_wr_en   (i_weight_wr_en),
        .i_weight_wr_addr (i_weight_wr_addr),
        .i_weight_wr_data (i_weight_wr_data),
        .o_kernel         (kernel),
        .o_bias           (bias),
        .o_scale          (scale)
    );

    // Pop the input as soon as a pixel is offered in LOAD
    assign o_fifo_rd_en = (state_q == LOAD) && i_valid;
    assign o_valid      = (state_q == EMIT);
    assign o_data       = out_q;

    // One output channel per cycle
    always_comb begin
        mac_sum = acc_t'(bias[ch_q]);
        for (int i = 0; i < IN_CH; i++) begin
            mac_sum += acc_t'(kernel[ch_q][i]) * acc_t'({1'b0, pixel_q[i]});
        end
    end

    // Requantize: ReLU, shift, clamp to 8 bits
    always_comb begin
        relu_sum  = mac_sum[`ACC_W-1] ? '0 : mac_sum;
        shifted   = relu_sum >>> scale;
        ch_result = (shifted > ACT_MAX) ? act_t'(ACT_MAX) : act_t'(shifted);
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_q <= LOAD;
            ch_q    <= '0;
        end else begin
            case (state_q)
                LOAD: begin
                    if (i_valid) begin
                        state_q <= MAC;
                        ch_q    <= '0;
                    end
                end
                MAC: begin
                    if (ch_q == CH_W'(OUT_CH - 1)) begin
                        state_q <= EMIT;
                    end else begin
                        ch_q <= ch_q + 1'b1;
                    end
                end
                EMIT: begin
                    state_q <= LOAD;    // Ready again next cycle
                end
                default: begin
                    state_q <= LOAD;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_fifo_rd_en) begin
            pixel_q <= i_data;
        end
        if (state_q == MAC) begin
            out_q[ch_q] <= ch_result;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, exit status is the result

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -sv -f sim.f --top-module tb_model -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_model
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit 1
fi

exit 0

/* sim.f */
+incdir+.
model_pkg.sv
weight_bank.sv
pw_conv.sv
act_fifo.sv
model.sv
tb_model.sv

/* tb_model.sv */
`timescale 1ns/10ps
`include "model_settings.svh"

module tb_model
    import model_pkg::*;
();

    localparam int N_ADDR      = `L2_SCALE_BASE + 1;
    localparam int N_SETS      = 3;
    localparam int TIMEOUT_CYC = 200;
    localparam int PIX_W       = `L1_IN_CH * `ACT_W;
    localparam int OUT_W       = `L2_OUT_CH * `ACT_W;

    typedef struct packed {
        logic [PIX_W-1:0] pixel;
        logic [OUT_W-1:0] expd;
        int               sel;      // Weight set loaded for this row
    } row_t;

    logic                  clk;
    logic                  i_rst_n;
    act_t [`L1_IN_CH-1:0]  i_data;
    logic                  i_valid;
    logic [`WR_DATA_W-1:0] i_weight_wr_data;
    logic [`WR_ADDR_W-1:0] i_weight_wr_addr;
    logic                  i_weight_wr_en;
    act_t [`L2_OUT_CH-1:0] o_data;
    logic                  o_valid;
    logic                  o_fifo_rd_en;

    int               wset [N_SETS][N_ADDR];
    int               cur_w [N_ADDR];     // What the DUT banks hold now
    row_t             rows [$];
    logic [OUT_W-1:0] exp_q [$];
    int               accepted;
    int               received;

    model i_model (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_data           (i_data),
        .i_valid          (i_valid),
        .i_weight_wr_data (i_weight_wr_data),
        .i_weight_wr_addr (i_weight_wr_addr),
        .i_weight_wr_en   (i_weight_wr_en),
        .o_data           (o_data),
        .o_valid          (o_valid),
        .o_fifo_rd_en     (o_fifo_rd_en)
    );

    always #50 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "stopped at first failure");
    endtask

    // ReLU, right shift, clamp to the 8 bit range
    function automatic int requant(input int sum, input int shamt);
        int v;
        v = (sum < 0) ? 0 : (sum >>> shamt);
        return (v > 255) ? 255 : v;
    endfunction

    function automatic logic [OUT_W-1:0] predict(input logic [PIX_W-1:0] pixel, input int sel);
        int               l1 [`L1_OUT_CH];
        int               sum;
        logic [OUT_W-1:0] res;
        for (int c = 0; c < `L1_OUT_CH; c++) begin
            sum = wset[sel][`L1_BIAS_BASE + c];
            for (int i = 0; i < `L1_IN_CH; i++) begin
                sum += wset[sel][`L1_KERNEL_BASE + c * `L1_IN_CH + i]
                       * int'(pixel[i*`ACT_W +: `ACT_W]);
            end
            l1[c] = requant(sum, wset[sel][`L1_SCALE_BASE]);
        end
        for (int c = 0; c < `L2_OUT_CH; c++) begin
            sum = wset[sel][`L2_BIAS_BASE + c];
            for (int i = 0; i < `L1_OUT_CH; i++) begin
                sum += wset[sel][`L2_KERNEL_BASE + c * `L1_OUT_CH + i] * l1[i];
            end
            res[c*`ACT_W +: `ACT_W] = `ACT_W'(requant(sum, wset[sel][`L2_SCALE_BASE]));
        end
        return res;
    endfunction

    task automatic init_weight_sets();
        // Set 0 with mixed signs
        wset[0] = '{1, 2, -1, -3, 1, 2, 2, -1, 1, -1, -1, -1,
                    10, -20, 5, 100,
                    2,
                    1, 1, -1, 2, -2, 1, 1, 1,
                    0, 8,
                    1};
        // Set 1 is large and positive everywhere for saturation
        wset[1] = '{127, 127, 127, 127, 127, 127, 127, 127, 127, 127, 127, 127,
                    0, 0, 0, 0,
                    0,
                    127, 127, 127, 127, 127, 127, 127, 127,
                    1000, 1000,
                    1};
        // Set 2 is set 0 with new layer 2 biases and scale
        wset[2] = wset[0];
        wset[2][`L2_BIAS_BASE]     = -5;
        wset[2][`L2_BIAS_BASE + 1] = 40;
        wset[2][`L2_SCALE_BASE]    = 0;
        for (int a = 0; a < N_ADDR; a++) begin
            cur_w[a] = 0;
        end
    endtask

    task automatic add_row(input logic [PIX_W-1:0] pixel, input logic [OUT_W-1:0] expd,
                           input int sel);
        row_t r;
        r.pixel = pixel;
        r.expd  = expd;
        r.sel   = sel;
        rows.push_back(r);
    endtask

    task automatic add_random_rows(input int n, input int sel);
        logic [PIX_W-1:0] pix;
        for (int k = 0; k < n; k++) begin
            pix = {8'($urandom()), 8'($urandom()), 8'($urandom())};
            add_row(pix, predict(pix, sel), sel);
        end
    endtask

    // Channel 0 sits in the low byte of pixel and result
    task automatic build_table();
        add_row({8'd255, 8'd255, 8'd255}, {8'd255, 8'd255}, 1);   // Saturation, lone pixel
        add_random_rows(3, 1);
        add_row({8'd0, 8'd0, 8'd0}, {8'd15, 8'd25}, 0);            // Biases only
        add_row({8'd0, 8'd0, 8'd200}, {8'd2, 8'd0}, 0);            // ReLU in both layers
        add_random_rows(12, 0);
        add_row({8'd0, 8'd0, 8'd0}, {8'd62, 8'd46}, 2);
        add_row({8'd0, 8'd0, 8'd200}, {8'd37, 8'd0}, 2);
        add_random_rows(4, 2);
    endtask

    // Called and returns 1 ns past a rising edge
    task automatic write_weight(input int addr, input int value);
        i_weight_wr_en   = 1'b1;
        i_weight_wr_addr = `WR_ADDR_W'(addr);
        i_weight_wr_data = `WR_DATA_W'(value);
        @(posedge clk);
        #1;
    endtask

    // Only addresses whose value changes go over the bus
    task automatic load_weight_set(input int sel);
        for (int a = 0; a < N_ADDR; a++) begin
            if (wset[sel][a] != cur_w[a]) begin
                write_weight(a, wset[sel][a]);
                cur_w[a] = wset[sel][a];
            end
        end
        i_weight_wr_en = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (received != accepted) begin
            if (cycles >= TIMEOUT_CYC) begin
                fail_run("Timed out waiting for o_valid of the accepted pixels");
            end else begin
                cycles++;
                @(posedge clk);
            end
        end
        #1;
    endtask

    task automatic wait_accept(input int r);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!o_fifo_rd_en) begin
            if (cycles >= TIMEOUT_CYC) begin
                fail_run($sformatf("Timed out waiting for o_fifo_rd_en on row %0d", r));
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
        @(posedge clk);
        #1;
    endtask

    // Samples DUT outputs on the falling edge
    always @(negedge clk) begin
        assert (!o_fifo_rd_en || i_valid)
            else fail_run($sformatf("ERROR %0t ns: o_fifo_rd_en high with no pixel offered",
                                    $time));
        if (o_valid) begin
            assert (exp_q.size() > 0)
                else fail_run($sformatf("ERROR %0t ns: o_valid with no pixel in flight", $time));
            assert (o_data == exp_q[0])
                else fail_run($sformatf("ERROR %0t ns: result %0d is %h, expected %h",
                                        $time, received, o_data, exp_q[0]));
            void'(exp_q.pop_front());
            received++;
        end
        if (o_fifo_rd_en) begin
            exp_q.push_back(rows[accepted].expd);
            accepted++;
        end
    end

    initial begin
        int cur_sel;
        clk              = 1'b0;
        i_rst_n          = 1'b0;
        i_data           = '0;
        i_valid          = 1'b0;
        i_weight_wr_data = '0;
        i_weight_wr_addr = '0;
        i_weight_wr_en   = 1'b0;
        accepted         = 0;
        received         = 0;
        void'($urandom(62));
        init_weight_sets();
        build_table();

        repeat (16) @(posedge clk);
        #1;
        i_rst_n = 1'b1;

        cur_sel = -1;
        for (int r = 0; r < rows.size(); r++) begin
            // Drain before a weight change and after the lone first pixel
            if (rows[r].sel != cur_sel || r == 1) begin
                i_valid = 1'b0;
                wait_drain();
                if (rows[r].sel != cur_sel) begin
                    load_weight_set(rows[r].sel);
                    cur_sel = rows[r].sel;
                end
            end
            i_data  = rows[r].pixel;
            i_valid = 1'b1;     // Stays high through a stream
            wait_accept(r);
        end
        i_valid = 1'b0;
        wait_drain();

        $display("sim passed");
        $finish;
    end

endmodule

/* weight_bank.sv */
`timescale 1ns/10ps
`include "model_settings.svh"

module weight_bank
    import model_pkg::*;
#(
    parameter int IN_CH       = `L1_IN_CH,
    parameter int OUT_CH      = `L1_OUT_CH,
    parameter int KERNEL_BASE = `L1_KERNEL_BASE,
    parameter int BIAS_BASE   = `L1_BIAS_BASE,
    parameter int SCALE_BASE  = `L1_SCALE_BASE
) (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_weight_wr_en,
    input  logic [`WR_ADDR_W-1:0] i_weight_wr_addr,
    input  logic [`WR_DATA_W-1:0] i_weight_wr_data,
    output weight_t               o_kernel [OUT_CH][IN_CH],
    output bias_t                 o_bias [OUT_CH],
    output scale_t                o_scale
);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int c = 0; c < OUT_CH; c++) begin
                for (int i = 0; i < IN_CH; i++) begin
                    o_kernel[c][i] <= '0;
                end
                o_bias[c] <= '0;
            end
            o_scale <= '0;
        end else if (i_weight_wr_en) begin
            // Each register answers to exactly one address
            for (int c = 0; c < OUT_CH; c++) begin
                for (int i = 0; i < IN_CH; i++) begin
                    if (i_weight_wr_addr == `WR_ADDR_W'(KERNEL_BASE + c * IN_CH + i)) begin
                        o_kernel[c][i] <= weight_t'(i_weight_wr_data[`WGT_W-1:0]);
                    end
                end
                if (i_weight_wr_addr == `WR_ADDR_W'(BIAS_BASE + c)) begin
                    o_bias[c] <= bias_t'(i_weight_wr_data[`BIAS_W-1:0]);
                end
            end
            if (i_weight_wr_addr == `WR_ADDR_W'(SCALE_BASE)) begin
                o_scale <= i_weight_wr_data[`SCALE_W-1:0];  // Low bits only
            end
        end
    end

endmodule
